/* Makefile */
VERILATOR  ?= verilator
VFLAGS     = --timing --assert
BUILD_FLAGS = --binary -j 0
TOP        = mem_tb
FILELIST   = project.f
BUILD_DIR  = obj_dir
LOG        = sim.log
SIM_ARGS   = +verilator+error+limit+1000
FAIL_MSG   = Simulation finished: FAIL
PASS_MSG   = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/mem_props.sv */
// Subsystem protocol checks
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_props import mem_pkg::*; (
    input logic                clk,
    input logic                rst_n,
    input logic                req_valid,
    input mem_op_e             req_op,
    input logic [`FILL_LW-1:0] req_len,
    input logic                busy,
    input logic                drop,
    input logic                rsp_valid
);

    int                fail_count = 0;  // failures seen so far
    logic              take_read;
    logic              fill_start;
    logic              bad_strobe;      // strobe the controller must drop
    logic [`FILL_LW:0] busy_left;       // fill words still owed

    assign take_read  = req_valid && !busy && (req_op == OP_READ);
    assign fill_start = req_valid && !busy && (req_op == OP_FILL);
    assign bad_strobe = req_valid && (busy || !(req_op inside {OP_READ, OP_WRITE, OP_FILL}));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_left <= '0;
        end else if (busy_left != '0) begin
            busy_left <= busy_left - 1'b1;
        end else if (fill_start) begin
            // zero is one word
            busy_left <= (req_len == '0) ? {{`FILL_LW{1'b0}}, 1'b1}
                                         : {1'b0, req_len};
        end
    end

    a_read_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        take_read |=> rsp_valid)
        else begin
            fail_count++;
            $error("no rsp_valid one cycle after a read strobe");
        end

    a_no_stray_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        !take_read |=> !rsp_valid)
        else begin
            fail_count++;
            $error("rsp_valid without a read strobe");
        end

    a_drop_timing: assert property (@(posedge clk) disable iff (!rst_n)
        drop == $past(bad_strobe))
        else begin
            fail_count++;
            $error("drop does not follow the offending strobe by one cycle");
        end

    a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
        busy == (busy_left != '0))
        else begin
            fail_count++;
            $error("busy length differs from the fill length");
        end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!busy && !drop && !rsp_valid))
        else begin
            fail_count++;
            $error("control output high during reset");
        end

endmodule

bind mem_subsys_top mem_props u_mem_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_op    (req_op),
    .req_len   (req_len),
    .busy      (busy),
    .drop      (drop),
    .rsp_valid (rsp_valid)
);

/* dv/mem_tb.sv */
// Scratch memory testbench
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_tb import mem_pkg::*; ();

    localparam int DEPTH = 2 ** `MEM_AW;
    // preload, write_read, stream, bank_alias, fill, drop, parity
    localparam int TEST_CYCLES = 280 + 30 + 20 + 12 + 40 + 40 + 12;
    localparam int CYCLE_LIMIT = 10 * TEST_CYCLES;

    logic                clk;
    logic                rst_n;
    logic                req_valid;
    mem_op_e             req_op;
    logic [`MEM_AW-1:0]  req_addr;
    logic [`MEM_BW-1:0]  req_be;
    logic [`MEM_DW-1:0]  req_data;
    logic [`FILL_LW-1:0] req_len;
    logic                inject_err;
    logic                busy;
    logic                drop;
    logic                rsp_valid;
    logic [`MEM_DW-1:0]  rsp_data;
    logic                rsp_err;

    logic [`MEM_DW-1:0]  model [DEPTH];      // expected contents
    logic                model_bad [DEPTH];  // byte 0 parity stored flipped
    logic [`MEM_DW-1:0]  exp_data [$];
    logic                exp_err [$];
    logic [31:0]         lcg_state;
    string               test_name;
    int                  errors;
    int                  checks;
    int                  cycles;
    int                  drops_expected;
    int                  drops_seen;

    mem_subsys_top u_mem_subsys_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_be     (req_be),
        .req_data   (req_data),
        .req_len    (req_len),
        .inject_err (inject_err),
        .busy       (busy),
        .drop       (drop),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_err    (rsp_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [`MEM_AW-1:0] pick_addr();
        logic [31:0] r;
        r = next_rand();
        return r[31 -: `MEM_AW];  // upper bits are the most random
    endfunction

    function automatic logic [`MEM_BW-1:0] lane_mask();
        logic [31:0] r;
        r = next_rand();
        return r[27 -: `MEM_BW];
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // one strobe, the reference model applies the same request rules
    task automatic issue(input mem_op_e op, input logic [`MEM_AW-1:0] addr,
                         input logic [`MEM_BW-1:0] be, input logic [`MEM_DW-1:0] data,
                         input logic [`FILL_LW-1:0] len);
        logic [`MEM_AW-1:0] a;
        int                 n;
        a = addr;
        n = (len == '0) ? 1 : int'(len);
        if (busy || !(op inside {OP_READ, OP_WRITE, OP_FILL})) begin
            drops_expected++;
        end else if (op == OP_READ) begin
            exp_data.push_back(model[addr]);
            exp_err.push_back(model_bad[addr]);
        end else if (op == OP_WRITE) begin
            for (int i = 0; i < `MEM_BW; i++) begin
                if (be[i]) begin
                    model[addr][8*i +: 8] = data[8*i +: 8];  // disabled lanes keep old bytes
                end
            end
            if (be[0]) begin
                model_bad[addr] = inject_err;
            end
        end else begin
            repeat (n) begin
                model[a]     = data;
                model_bad[a] = inject_err;
                a            = a + 1'b1;  // wraps past the top address
            end
        end
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_be    = be;
        req_data  = data;
        req_len   = len;
        step();
        req_valid = 1'b0;
    endtask

    task automatic read_word(input logic [`MEM_AW-1:0] addr);
        issue(OP_READ, addr, '0, '0, '0);
    endtask

    task automatic write_word(input logic [`MEM_AW-1:0] addr, input logic [`MEM_BW-1:0] be,
                              input logic [`MEM_DW-1:0] data);
        issue(OP_WRITE, addr, be, data, '0);
    endtask

    // fill, then count the cycles busy stays high
    task automatic fill_run(input logic [`MEM_AW-1:0] addr, input logic [`FILL_LW-1:0] len,
                            input logic [`MEM_DW-1:0] data);
        int n;
        int want;
        n    = 0;
        want = (len == '0) ? 1 : int'(len);
        issue(OP_FILL, addr, '1, data, len);
        while (busy) begin
            n++;
            step();
        end
        checks++;
        assert (n == want) else begin
            errors++;
            $display("ERR %s busy cycles expected %0d actual %0d", test_name, want, n);
        end
    endtask

    task automatic drain();
        while (exp_data.size() != 0) begin
            step();
        end
    endtask

    task automatic check_drops();
        checks++;
        assert (drops_seen == drops_expected) else begin
            errors++;
            $display("ERR %s drops expected %0d actual %0d", test_name, drops_expected,
                     drops_seen);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin : check_rsp
        logic [`MEM_DW-1:0] want_data;
        logic               want_err;
        if (rst_n && drop) begin
            drops_seen++;
        end
        if (rst_n && rsp_valid) begin
            checks++;
            assert (exp_data.size() != 0) else begin
                errors++;
                $display("response arrived in %s with no read outstanding", test_name);
            end
            if (exp_data.size() != 0) begin
                want_data = exp_data.pop_front();
                want_err  = exp_err.pop_front();
                assert (rsp_data === want_data) else begin
                    errors++;
                    $display("ERR %s data expected %h actual %h", test_name, want_data, rsp_data);
                end
                assert (rsp_err === want_err) else begin
                    errors++;
                    $display("ERR %s rsp_err expected %b actual %b", test_name, want_err, rsp_err);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %s did not complete", cycles, test_name);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [`MEM_AW-1:0] addrs [12];
        logic [`MEM_AW-1:0] a;
        int                 prop_fails;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req_op         = OP_READ;
        req_addr       = '0;
        req_be         = '0;
        req_data       = '0;
        req_len        = '0;
        inject_err     = 1'b0;
        lcg_state      = 32'he405a327;
        errors         = 0;
        checks         = 0;
        drops_expected = 0;
        drops_seen     = 0;
        test_name      = "reset";
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        step();

        test_name = "preload";  // every word gets a known value
        fill_run(8'h00, 8'd128, next_rand());
        fill_run(8'h80, 8'd128, next_rand());

        test_name = "write_read";
        for (int i = 0; i < 12; i++) begin
            addrs[i] = pick_addr();
            write_word(addrs[i], lane_mask(), next_rand());
        end
        for (int i = 0; i < 12; i++) begin
            read_word(addrs[i]);
        end
        drain();

        test_name = "stream";
        repeat (16) read_word(pick_addr());
        drain();

        test_name = "bank_alias";
        a = 8'h05;
        repeat (4) begin
            write_word(a, '1, next_rand());
            a = a + 8'h40;  // same macro row, next bank
        end
        repeat (4) begin
            read_word(a);
            a = a + 8'h40;
        end
        drain();

        test_name = "fill_wrap";  // crosses bank 3 into bank 0
        fill_run(8'hFA, 8'd12, next_rand());
        a = 8'hF9;
        repeat (14) begin
            read_word(a);
            a = a + 1'b1;
        end
        test_name = "fill_zero";
        fill_run(8'h40, 8'd0, next_rand());
        read_word(8'h3F);
        read_word(8'h40);
        read_word(8'h41);
        drain();

        test_name = "drop";
        issue(OP_FILL, 8'h3C, '1, next_rand(), 8'd8);
        read_word(8'h10);
        write_word(8'h80, '1, next_rand());
        issue(OP_FILL, 8'h90, '1, next_rand(), 8'd4);
        while (busy) begin
            step();
        end
        issue(mem_op_e'(2'b11), 8'h81, '1, next_rand(), 8'd0);
        a = 8'h3B;
        repeat (10) begin
            read_word(a);
            a = a + 1'b1;
        end
        read_word(8'h80);
        read_word(8'h81);
        read_word(8'h90);
        read_word(8'h93);
        drain();
        step();
        check_drops();

        test_name  = "parity";
        inject_err = 1'b1;
        write_word(8'h22, '1, next_rand());
        inject_err = 1'b0;
        read_word(8'h22);
        write_word(8'h22, '1, next_rand());
        read_word(8'h22);
        drain();
        step();

        prop_fails = u_mem_subsys_top.u_mem_props.fail_count;
        $display("checks %0d, data errors %0d, assertion failures %0d", checks, errors,
                 prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* logic/byte_parity.sv */
// Byte parity codec
`timescale 1ns/1ps
`include "mem_macros.svh"

module byte_parity import mem_pkg::*; (
    input logic      inject_err,
    cmd_if.codec     cmd,
    store_if.codec   store
);

    logic [`MEM_BW-1:0] wpar;  // parity bits to store
    logic [`MEM_BW-1:0] rbad;  // per byte read mismatch

    assign store.ce   = cmd.ce;
    assign store.we   = cmd.we;
    assign store.addr = cmd.addr;

    // even parity per byte, byte 0 flipped for production test
    always_comb begin
        for (int i = 0; i < `MEM_BW; i++) begin
            wpar[i] = ^cmd.wdata[8*i +: 8];
        end
        wpar[0] = wpar[0] ^ inject_err;
    end

    // layout per lane is {parity, byte}
    always_comb begin
        store.din   = '0;
        store.wmask = '0;
        for (int i = 0; i < `MEM_BW; i++) begin
            store.din[9*i +: 8]   = cmd.wdata[8*i +: 8];
            store.din[9*i + 8]    = wpar[i];
            store.wmask[9*i +: 9] = {9{cmd.be[i]}};  // byte enable covers its parity bit
        end
    end

    always_comb begin
        for (int i = 0; i < `MEM_BW; i++) begin
            cmd.rdata[8*i +: 8] = store.dout[9*i +: 8];
            rbad[i]             = ^store.dout[9*i +: 9];  // odd count means bad lane
        end
    end

    assign cmd.rerr = |rbad;

endmodule

/* logic/mem_ctrl.sv */
// Request controller
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_ctrl import mem_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  mem_op_e             req_op,
    input  logic [`MEM_AW-1:0]  req_addr,
    input  logic [`MEM_BW-1:0]  req_be,
    input  logic [`MEM_DW-1:0]  req_data,
    input  logic [`FILL_LW-1:0] req_len,
    output logic                busy,
    output logic                drop,
    output logic                rsp_valid,
    output logic [`MEM_DW-1:0]  rsp_data,
    output logic                rsp_err,
    cmd_if.ctrl                 cmd
);

    logic                take;       // strobe accepted in idle
    logic                op_known;
    logic [`MEM_AW-1:0]  fill_addr;
    logic [`FILL_LW-1:0] remain;     // fill words still to write
    logic [`MEM_DW-1:0]  fill_data;

    assign op_known = (req_op == OP_READ) || (req_op == OP_WRITE) || (req_op == OP_FILL);
    assign take     = req_valid && !busy && op_known;

    // busy doubles as the state bit, low is idle and high is fill
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            drop      <= 1'b0;
            rsp_valid <= 1'b0;
            fill_addr <= '0;
            remain    <= '0;
        end else begin
            rsp_valid <= take && (req_op == OP_READ);  // same edge as macro read
            drop      <= req_valid && (busy || !op_known);
            if (busy) begin
                fill_addr <= fill_addr + 1'b1;  // wraps modulo depth
                remain    <= remain - 1'b1;
                if (remain == `FILL_LW'(1)) begin
                    busy <= 1'b0;
                end
            end else if (take && (req_op == OP_FILL)) begin
                busy      <= 1'b1;
                fill_addr <= req_addr;
                remain    <= (req_len == '0) ? `FILL_LW'(1) : req_len;  // zero means one word
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && (req_op == OP_FILL)) begin
            fill_data <= req_data;
        end
    end

    always_comb begin
        if (busy) begin
            cmd.ce    = 1'b1;
            cmd.we    = 1'b1;
            cmd.be    = '1;  // fill writes whole words
            cmd.addr  = fill_addr;
            cmd.wdata = fill_data;
        end else begin
            cmd.ce    = take && (req_op != OP_FILL);
            cmd.we    = take && (req_op == OP_WRITE);
            cmd.be    = req_be;
            cmd.addr  = req_addr;
            cmd.wdata = req_data;
        end
    end

    // response fields are quiet outside the response cycle
    assign rsp_data = rsp_valid ? cmd.rdata : '0;
    assign rsp_err  = rsp_valid && cmd.rerr;

endmodule

/* logic/mem_ifs.sv */
// Memory access interfaces
`timescale 1ns/1ps
`include "mem_macros.svh"

// word level access, controller to parity codec
interface cmd_if;
    logic                ce;
    logic                we;
    logic [`MEM_BW-1:0]  be;     // byte enables
    logic [`MEM_AW-1:0]  addr;
    logic [`MEM_DW-1:0]  wdata;
    logic [`MEM_DW-1:0]  rdata;
    logic                rerr;   // parity mismatch on read data

    modport ctrl (
        output ce, we, be, addr, wdata,
        input  rdata, rerr
    );

    modport codec (
        input  ce, we, be, addr, wdata,
        output rdata, rerr
    );
endinterface

// stored word access, parity codec to tiler
interface store_if import mem_pkg::*; ();
    logic                ce;
    logic                we;
    logic [STORE_W-1:0]  wmask;  // per bit write mask
    logic [`MEM_AW-1:0]  addr;
    logic [STORE_W-1:0]  din;
    logic [STORE_W-1:0]  dout;

    modport codec (
        output ce, we, wmask, addr, din,
        input  dout
    );

    modport ram (
        input  ce, we, wmask, addr, din,
        output dout
    );
endinterface

/* logic/mem_macros.svh */
// Scratch memory size parameters
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// user side word and address
`define MEM_DW 32
`define MEM_AW 8

// one hard macro, 64 words of 32 bits
`define MACRO_AW 6
`define MACRO_W 32

// byte lanes in a user word
`define MEM_BW (`MEM_DW / 8)

// fill run length port
`define FILL_LW 8

`endif

/* logic/mem_pkg.sv */
// Scratch memory types
`include "mem_macros.svh"

package mem_pkg;

    // each data byte is followed by its even parity bit
    localparam int STORE_W = `MEM_DW + `MEM_BW;

    // code 2'b11 is reserved, the controller drops it
    typedef enum logic [1:0] {
        OP_READ  = 2'b00,
        OP_WRITE = 2'b01,
        OP_FILL  = 2'b10
    } mem_op_e;

endpackage

/* logic/mem_subsys_top.sv */
// Scratch memory subsystem top
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_top import mem_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  mem_op_e             req_op,
    input  logic [`MEM_AW-1:0]  req_addr,
    input  logic [`MEM_BW-1:0]  req_be,
    input  logic [`MEM_DW-1:0]  req_data,
    input  logic [`FILL_LW-1:0] req_len,
    input  logic                inject_err,
    output logic                busy,
    output logic                drop,
    output logic                rsp_valid,
    output logic [`MEM_DW-1:0]  rsp_data,
    output logic                rsp_err
);

    cmd_if   cmd_bus ();
    store_if store_bus ();

    mem_ctrl u_mem_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_be    (req_be),
        .req_data  (req_data),
        .req_len   (req_len),
        .busy      (busy),
        .drop      (drop),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_err   (rsp_err),
        .cmd       (cmd_bus.ctrl)
    );

    byte_parity u_byte_parity (
        .inject_err (inject_err),
        .cmd        (cmd_bus.codec),
        .store      (store_bus.codec)
    );

    spram_tiler u_spram_tiler (
        .clk   (clk),
        .rst_n (rst_n),
        .ram   (store_bus.ram)
    );

endmodule

/* logic/spram_tiler.sv */
// Macro bank and column tiler
`timescale 1ns/1ps
`include "mem_macros.svh"

module spram_tiler import mem_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    store_if.ram   ram
);

    localparam int BANKS = 2 ** (`MEM_AW - `MACRO_AW);
    localparam int COLS  = (STORE_W + `MACRO_W - 1) / `MACRO_W;
    localparam int PAD_W = COLS * `MACRO_W;
    localparam int SEL_W = (BANKS > 1) ? $clog2(BANKS) : 1;

    logic [SEL_W-1:0]     bank;     // bank addressed this cycle
    logic [SEL_W-1:0]     rd_bank;  // bank that produced the read data
    logic [PAD_W-1:0]     din_pad;
    logic [PAD_W-1:0]     wmask_pad;
    logic [PAD_W-1:0]     bank_rd [BANKS];
    logic [PAD_W-1:0]     merged;

    assign bank = SEL_W'(ram.addr >> `MACRO_AW);

    // unused column bits carry zero data and zero mask
    assign din_pad   = PAD_W'(ram.din);
    assign wmask_pad = PAD_W'(ram.wmask);

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        logic             sel;
        logic [PAD_W-1:0] row_rd;

        assign sel        = (bank == SEL_W'(b));
        assign bank_rd[b] = row_rd;

        for (genvar c = 0; c < COLS; c++) begin : g_col
            sram_macro #(
                .MACRO_AW (`MACRO_AW),
                .MACRO_W  (`MACRO_W)
            ) u_sram_macro (
                .clk   (clk),
                .ce    (ram.ce && sel),
                .we    (ram.we && sel),
                .wmask (wmask_pad[c*`MACRO_W +: `MACRO_W]),
                .addr  (ram.addr[`MACRO_AW-1:0]),
                .wd    (din_pad[c*`MACRO_W +: `MACRO_W]),
                .rd    (row_rd[c*`MACRO_W +: `MACRO_W])
            );
        end
    end

    // selection follows the macro read register by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_bank <= '0;
        end else if (ram.ce && !ram.we) begin
            rd_bank <= bank;
        end
    end

    always_comb begin
        merged = '0;
        for (int b = 0; b < BANKS; b++) begin
            merged |= bank_rd[b] & {PAD_W{rd_bank == SEL_W'(b)}};  // or-merge of gated banks
        end
    end

    assign ram.dout = merged[STORE_W-1:0];

endmodule

/* logic/sram_macro.sv */
// Single port macro model
`timescale 1ns/1ps
`include "mem_macros.svh"

module sram_macro #(
    parameter int MACRO_AW = `MACRO_AW,
    parameter int MACRO_W  = `MACRO_W
) (
    input  logic                clk,
    input  logic                ce,
    input  logic                we,
    input  logic [MACRO_W-1:0]  wmask,
    input  logic [MACRO_AW-1:0] addr,
    input  logic [MACRO_W-1:0]  wd,
    output logic [MACRO_W-1:0]  rd
);

    logic [MACRO_W-1:0] mem [2**MACRO_AW];

    always_ff @(posedge clk) begin
        if (ce) begin
            if (we) begin
                // only masked bits change
                mem[addr] <= (mem[addr] & ~wmask) | (wd & wmask);
            end else begin
                rd <= mem[addr];  // rd holds between reads
            end
        end
    end

endmodule

/* project.f */
+incdir+logic
logic/mem_pkg.sv
logic/mem_ifs.sv
logic/sram_macro.sv
logic/spram_tiler.sv
logic/byte_parity.sv
logic/mem_ctrl.sv
logic/mem_subsys_top.sv
dv/mem_props.sv
dv/mem_tb.sv
